// File: src/avg_pkg.sv
package avg_pkg;

   // sample and average width.
   localparam int SAMPLE_W = 8;

   // samples beyond this count in one burst are dropped.
   localparam int MAX_SAMPLES = 1000;

   // count holds 0 to MAX_SAMPLES.
   localparam int CNT_W = 10;

   // sum holds 255 * MAX_SAMPLES.
   localparam int SUM_W = 18;

   // one quotient bit per iteration.
   localparam int DIV_ITER = SUM_W;
   localparam int ITER_W = $clog2(DIV_ITER + 1);

   typedef struct packed {
      logic [SAMPLE_W-1:0] data;
      logic                valid; // strobe, one sample per cycle while high.
   } sample_t;

   typedef struct packed {
      logic [SAMPLE_W-1:0] avg;       // truncated floor average.
      logic [CNT_W-1:0]    n_samples; // accepted samples of the burst.
   } avg_result_t;

endpackage

// File: src/ehgu_cntr.sv
module ehgu_cntr (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      sync_clr,
   input  logic                      en,
   output logic [avg_pkg::CNT_W-1:0] cnt
);
   import avg_pkg::*;

   logic [CNT_W-1:0] cnt_next;

   // clear wins over enable; both high counts the first sample of a new burst.
   always_comb begin
      if (sync_clr) begin
         cnt_next = en ? CNT_W'(1) : '0;
      end else if (en) begin
         cnt_next = cnt + 1'b1;
      end else begin
         cnt_next = cnt;
      end
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         cnt <= '0;
      end else begin
         cnt <= cnt_next;
      end
   end

endmodule

// File: src/avg_divider.sv
module avg_divider (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      div_start,
   input  logic [avg_pkg::SUM_W-1:0] dividend,
   input  logic [avg_pkg::CNT_W-1:0] divisor,
   output logic [avg_pkg::SUM_W-1:0] quotient,
   output logic                      div_done
);
   import avg_pkg::*;

   logic [CNT_W-1:0]  rem;     // partial remainder, always below dvsr.
   logic [CNT_W-1:0]  dvsr;    // divisor captured at start.
   logic [ITER_W-1:0] iter;    // iterations still to run.
   logic [CNT_W:0]    shifted; // remainder with the next dividend bit brought in.
   logic [CNT_W-1:0]  diff;
   logic              fits;
   logic              busy;

   assign busy = (iter != '0);

   // dividend bits leave the top of quotient while quotient bits enter below.
   assign shifted = {rem, quotient[SUM_W-1]};
   assign fits    = (shifted >= {1'b0, dvsr});
   assign diff    = CNT_W'(shifted - {1'b0, dvsr});

   // iteration count and done pulse.
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         iter     <= '0;
         div_done <= 1'b0;
      end else begin
         div_done <= 1'b0;
         if (div_start) begin
            iter <= ITER_W'(DIV_ITER);
         end else if (busy) begin
            iter     <= iter - 1'b1;
            div_done <= (iter == ITER_W'(1)); // last bit lands on this edge.
         end
      end
   end

   // datapath, one restoring step per cycle.
   always_ff @(posedge clk) begin
      if (div_start) begin
         rem      <= '0;
         dvsr     <= divisor;
         quotient <= dividend;
      end else if (busy) begin
         if (fits) begin
            rem <= diff;
         end else begin
            rem <= shifted[CNT_W-1:0]; // below dvsr, so top bit is zero.
         end
         quotient <= {quotient[SUM_W-2:0], fits};
      end
   end

endmodule

// File: src/sample_avg.sv
module sample_avg (
   input  logic                      clk,
   input  logic                      rstn,
   input  avg_pkg::sample_t          in,
   input  logic [avg_pkg::CNT_W-1:0] cnt,
   output logic                      cnt_clr,
   output logic                      cnt_en,
   output logic                      div_start,
   output logic [avg_pkg::SUM_W-1:0] dividend,
   output logic [avg_pkg::CNT_W-1:0] divisor,
   input  logic [avg_pkg::SUM_W-1:0] quotient,
   input  logic                      div_done,
   output avg_pkg::avg_result_t      result,
   output logic                      avg_valid
);
   import avg_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      ACCUM,
      DIVIDE,
      HOLD
   } state_t;

   state_t           state;
   state_t           next_state;
   logic [SUM_W-1:0] sum;
   logic             below_max;
   logic             accept;

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         state <= IDLE;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         IDLE: begin
            if (in.valid) begin
               next_state = ACCUM;
            end
         end
         ACCUM: begin
            if (!in.valid) begin
               next_state = DIVIDE; // burst ended, divider starts now.
            end
         end
         DIVIDE: begin
            if (div_done) begin
               next_state = HOLD;
            end
         end
         HOLD: begin
            if (in.valid) begin
               next_state = ACCUM;
            end
         end
         default: begin
            next_state = IDLE;
         end
      endcase
   end

   // a new burst restarts the count even if the old one hit the limit.
   assign below_max = (cnt < CNT_W'(MAX_SAMPLES));
   assign cnt_clr   = (state == HOLD) && in.valid;
   assign accept    = in.valid && (state != DIVIDE) && (cnt_clr || below_max);
   assign cnt_en    = accept;

   assign div_start = (state == ACCUM) && !in.valid;
   assign dividend  = sum;
   assign divisor   = cnt;

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         sum <= '0;
      end else if (accept) begin
         if (cnt_clr) begin
            sum <= SUM_W'(in.data);
         end else begin
            sum <= sum + SUM_W'(in.data);
         end
      end
   end

   // result stays put until the next division completes.
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         result <= '0;
      end else if ((state == DIVIDE) && div_done) begin
         result.avg       <= quotient[SAMPLE_W-1:0];
         result.n_samples <= cnt;
      end
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         avg_valid <= 1'b0;
      end else begin
         avg_valid <= (state == HOLD); // one edge behind the state.
      end
   end

endmodule

// File: src/avg_top.sv
module avg_top (
   input  logic                 clk,
   input  logic                 rstn,
   input  avg_pkg::sample_t     in,
   output avg_pkg::avg_result_t result,
   output logic                 avg_valid
);
   import avg_pkg::*;

   logic             cnt_clr;
   logic             cnt_en;
   logic [CNT_W-1:0] cnt;
   logic             div_start;
   logic             div_done;
   logic [SUM_W-1:0] dividend;
   logic [CNT_W-1:0] divisor;
   logic [SUM_W-1:0] quotient;

   sample_avg sample_avg_inst (
      .clk       (clk),
      .rstn      (rstn),
      .in        (in),
      .cnt       (cnt),
      .cnt_clr   (cnt_clr),
      .cnt_en    (cnt_en),
      .div_start (div_start),
      .dividend  (dividend),
      .divisor   (divisor),
      .quotient  (quotient),
      .div_done  (div_done),
      .result    (result),
      .avg_valid (avg_valid)
   );

   ehgu_cntr cntr_inst (
      .clk      (clk),
      .rstn     (rstn),
      .sync_clr (cnt_clr),
      .en       (cnt_en),
      .cnt      (cnt)
   );

   avg_divider divider_inst (
      .clk       (clk),
      .rstn      (rstn),
      .div_start (div_start),
      .dividend  (dividend),
      .divisor   (divisor),
      .quotient  (quotient),
      .div_done  (div_done)
   );

endmodule

// File: verification/avg_top_tb.sv
module avg_top_tb;
   import avg_pkg::*;

   localparam int CLK_PERIOD = 10;
   localparam int RESULT_TIMEOUT = 40; // cycles to wait for avg_valid.
   localparam int SRC_CONST = 0;
   localparam int SRC_RANDOM = 1;
   localparam int SRC_LIST = 2;

   // run length: samples driven by all tests, bursts with their result wait and gaps.
   localparam int SAMPLE_CYCLES = 5 + 10 * 40 + 1 + 7 + 6 + 10 + 1005;
   localparam int BURST_COUNT = 15;
   localparam int PER_BURST = DIV_ITER + 2 + 10;
   localparam int MARGIN_CYCLES = 1000;
   localparam int WATCHDOG_TIME =
      (13 + SAMPLE_CYCLES + BURST_COUNT * PER_BURST + MARGIN_CYCLES) * CLK_PERIOD;

   logic        clk;
   logic        rstn;
   sample_t     in_sample;
   avg_result_t result;
   logic        avg_valid;

   integer      seed;
   int          errors;
   int          checks;
   int          exp_sum; // reference model of the accepted samples.
   int          exp_cnt;
   logic        result_held; // a finished result is on the outputs.
   logic [7:0]  list_q[$];

   avg_top avg_top_inst (
      .clk       (clk),
      .rstn      (rstn),
      .in        (in_sample),
      .result    (result),
      .avg_valid (avg_valid)
   );

   initial begin
      clk = 1'b0;
   end

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic idle_cycles(input int n, input logic exp_valid);
      repeat (n) begin
         @(posedge clk);
         #1;
         check_val("avg_valid while idle", 32'(avg_valid), 32'(exp_valid));
         if (exp_valid) begin
            check_result();
         end
      end
   endtask

   // drives len samples back to back, then one idle cycle that ends the burst.
   task automatic send_burst(input int len, input int src, input logic [7:0] value);
      int          i;
      logic [7:0]  d;
      logic [31:0] r;
      exp_sum = 0;
      exp_cnt = 0;
      for (i = 0; i <= len; i++) begin
         @(posedge clk);
         #1;
         if (i == 1) begin
            check_val("avg_valid one edge into burst", 32'(avg_valid), 32'(result_held));
         end
         if (i == 2) begin
            check_val("avg_valid after burst start", 32'(avg_valid), 32'd0);
         end
         if (i < len) begin
            case (src)
               SRC_RANDOM: begin
                  r = $random(seed);
                  d = r[7:0];
               end
               SRC_LIST: d = list_q[i];
               default: d = value;
            endcase
            in_sample.valid = 1'b1;
            in_sample.data  = d;
            if (exp_cnt < MAX_SAMPLES) begin
               exp_sum += int'(d);
               exp_cnt++;
            end
         end else begin
            in_sample.valid = 1'b0;
            in_sample.data  = '0;
         end
      end
   endtask

   // lat counts edges from the first edge with valid low to the rise of avg_valid.
   task automatic wait_result(output int lat);
      int   n;
      logic seen;
      n    = 0;
      seen = 1'b0;
      lat  = -1;
      while (!seen && n < RESULT_TIMEOUT) begin
         @(posedge clk);
         #1;
         if (n == 0) begin
            check_val("avg_valid at burst end", 32'(avg_valid), 32'd0);
         end else if (avg_valid) begin
            seen = 1'b1;
            lat  = n;
         end
         n++;
      end
      result_held = seen;
      if (!seen) begin
         errors++;
         $display("Timeout: avg_valid did not rise within %0d cycles after the burst",
                  RESULT_TIMEOUT);
      end
   endtask

   task automatic check_result();
      check_val("average", 32'(result.avg), 32'(exp_sum / exp_cnt));
      check_val("n_samples", 32'(result.n_samples), 32'(exp_cnt));
   endtask

   task automatic test_reset_idle();
      repeat (10) begin
         @(posedge clk);
         #1;
         check_val("avg_valid after reset", 32'(avg_valid), 32'd0);
         check_val("result after reset", 32'(result), 32'd0);
      end
   endtask

   task automatic test_fixed_burst();
      int lat;
      list_q = '{8'd12, 8'd200, 8'd37, 8'd99, 8'd250};
      send_burst(5, SRC_LIST, 8'd0);
      wait_result(lat);
      check_val("result latency", 32'(lat), 32'(DIV_ITER + 2));
      check_result();
      check_val("n_samples of fixed burst", 32'(result.n_samples), 32'd5);
   endtask

   task automatic test_random_bursts();
      int          b;
      int          len;
      int          lat;
      logic [31:0] r;
      for (b = 0; b < 10; b++) begin
         r   = $random(seed);
         len = 1 + int'(r[15:0] % 16'd40);
         send_burst(len, SRC_RANDOM, 8'd0);
         wait_result(lat);
         check_result();
         r = $random(seed);
         idle_cycles(1 + int'(r[3:0] % 4'd5), 1'b1); // result held across the gap.
      end
   endtask

   task automatic test_corner_values();
      int lat;
      send_burst(1, SRC_CONST, 8'hff);
      wait_result(lat);
      check_val("single sample average", 32'(result.avg), 32'd255);
      check_val("single sample count", 32'(result.n_samples), 32'd1);
      send_burst(7, SRC_CONST, 8'h00);
      wait_result(lat);
      check_val("zero burst average", 32'(result.avg), 32'd0);
      check_val("zero burst count", 32'(result.n_samples), 32'd7);
   endtask

   task automatic test_busy_samples();
      int          i;
      int          lat;
      logic [31:0] r;
      send_burst(6, SRC_RANDOM, 8'd0);
      @(posedge clk); // divider starts on this edge.
      #1;
      for (i = 0; i < 10; i++) begin
         r = $random(seed);
         in_sample.valid = 1'b1;
         in_sample.data  = r[7:0];
         @(posedge clk);
         #1;
      end
      in_sample.valid = 1'b0;
      in_sample.data  = '0;
      wait_result(lat);
      check_result();
      idle_cycles(5, 1'b1);
   endtask

   task automatic test_sample_limit();
      int lat;
      send_burst(1005, SRC_RANDOM, 8'd0);
      wait_result(lat);
      check_val("n_samples at limit", 32'(result.n_samples), 32'(MAX_SAMPLES));
      check_result();
   endtask

   initial begin
      seed        = 32'haf9bf015;
      errors      = 0;
      checks      = 0;
      exp_sum     = 0;
      exp_cnt     = 0;
      result_held = 1'b0;
      rstn        = 1'b0;
      in_sample   = '0;
      repeat (3) @(posedge clk);
      #1;
      rstn = 1'b1;
      test_reset_idle();
      test_fixed_burst();
      test_random_bursts();
      test_corner_values();
      test_busy_samples();
      test_sample_limit();
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_TIME);
      $display("Watchdog expired before all tests finished, errors so far: %0d", errors);
      $display("Simulation failed");
      $finish;
   end

endmodule

// File: build.f
src/avg_pkg.sv
src/ehgu_cntr.sv
src/avg_divider.sv
src/sample_avg.sv
src/avg_top.sv
verification/avg_top_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module avg_top_tb -f build.f -o avg_sim \
   > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/avg_sim > sim.log 2>&1 || echo "simulator returned a non-zero status"
grep -q "Simulation completed successfully" sim.log && echo "PASS" || {
   echo "FAIL, see sim.log"
   exit 1
}
exit 0
